//--- rtl/fixed_point_pkg.sv
`default_nettype none

package fixed_point_pkg;

  // word width of one real or imaginary part
  localparam int sample_width = 16;

  // Q2.14, so +1.0 is 16384
  localparam int frac_bits = 14;

  // one real or imaginary part, two's complement
  typedef logic signed [sample_width-1:0] sample_t;

  // full product before the shift back to Q2.14
  typedef logic signed [2*sample_width-1:0] product_t;

endpackage

`default_nettype wire

//--- rtl/butterfly_pkg.sv
`default_nettype none

package butterfly_pkg;

  // transform size served by the twiddle table
  localparam int fft_points = 8;

  // a radix-2 stage only needs the first half of the twiddles, W8^0..W8^3
  localparam int twiddle_index_width = $clog2(fft_points) - 1;

  typedef logic [twiddle_index_width-1:0] twiddle_index_t;

  // sequencer of the shared-multiplier complex product
  typedef enum logic [2:0] {
    idle,
    mul_rr,
    mul_ii,
    mul_sum,
    done
  } cmul_state_t;

endpackage

`default_nettype wire

//--- rtl/fixed_mult.sv
`default_nettype none

module fixed_mult (
  input  fixed_point_pkg::sample_t a,
  input  fixed_point_pkg::sample_t b,
  output fixed_point_pkg::sample_t c
);

  import fixed_point_pkg::*;

  // full-width signed product, Q4.28
  product_t full;
  // product realigned to the Q2.14 binary point
  product_t shifted;

  // both operands sign-extended to 32 bits before the multiply
  assign full = product_t'(a) * product_t'(b);

  // arithmetic shift keeps the sign, i.e. rounds toward minus infinity
  assign shifted = full >>> frac_bits;

  // keep the low word, upper bits are dropped and the result wraps
  assign c = shifted[sample_width-1:0];

endmodule

`default_nettype wire

//--- rtl/complex_mult.sv
`default_nettype none

module complex_mult #(
  parameter int num_mults = 1
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     recv_val,
  output logic                     recv_rdy,
  output logic                     send_val,
  input  logic                     send_rdy,
  input  fixed_point_pkg::sample_t a_re,
  input  fixed_point_pkg::sample_t a_im,
  input  fixed_point_pkg::sample_t b_re,
  input  fixed_point_pkg::sample_t b_im,
  output fixed_point_pkg::sample_t c_re,
  output fixed_point_pkg::sample_t c_im
);

  import fixed_point_pkg::*;
  import butterfly_pkg::*;

  // c_re = a_re*b_re - a_im*b_im
  // c_im = (a_re + a_im)(b_re + b_im) - a_re*b_re - a_im*b_im
  // three real products instead of four

  generate
    if (num_mults == 3) begin : g_three
      sample_t a_sum;
      sample_t b_sum;
      sample_t p_rr;
      sample_t p_ii;
      sample_t p_sum;

      // operand sums wrap at 16 bits like every other add
      assign a_sum = a_re + a_im;
      assign b_sum = b_re + b_im;

      fixed_mult u_mult_rr (.a(a_re),  .b(b_re),  .c(p_rr));
      fixed_mult u_mult_ii (.a(a_im),  .b(b_im),  .c(p_ii));
      fixed_mult u_mult_sum (.a(a_sum), .b(b_sum), .c(p_sum));

      assign c_re = p_rr - p_ii;
      assign c_im = p_sum - p_rr - p_ii;

      // purely combinational, handshake passes straight through
      assign send_val = recv_val;
      assign recv_rdy = send_rdy;
    end else begin : g_one
      cmul_state_t state;
      cmul_state_t state_next;
      // set for one cycle after acceptance, kicks off the sequence
      logic    start;
      logic    accept;
      // operands latched at acceptance
      sample_t op_a_re;
      sample_t op_a_im;
      sample_t op_b_re;
      sample_t op_b_im;
      // shared multiplier
      sample_t mul_a;
      sample_t mul_b;
      sample_t mul_c;
      // stored partial products
      sample_t p_rr;
      sample_t p_ii;
      sample_t p_sum;

      // one item in flight, so only take new work when fully idle
      assign recv_rdy = (state == idle) && !start;
      assign accept   = recv_val && recv_rdy;
      assign send_val = (state == done);

      always_ff @(posedge clk) begin
        if (reset) begin
          state <= idle;
          start <= 1'b0;
        end else begin
          state <= state_next;
          start <= accept;
        end
      end

      always_ff @(posedge clk) begin
        if (accept) begin
          op_a_re <= a_re;
          op_a_im <= a_im;
          op_b_re <= b_re;
          op_b_im <= b_im;
        end
        // each product lands on the edge that leaves its state
        case (state)
          mul_rr:  p_rr  <= mul_c;
          mul_ii:  p_ii  <= mul_c;
          mul_sum: p_sum <= mul_c;
          default: ;
        endcase
      end

      always_comb begin
        state_next = state;
        // real x real by default
        mul_a = op_a_re;
        mul_b = op_b_re;
        case (state)
          idle: begin
            if (start) begin
              state_next = mul_rr;
            end
          end
          mul_rr: state_next = mul_ii;
          mul_ii: begin
            state_next = mul_sum;
            mul_a      = op_a_im;
            mul_b      = op_b_im;
          end
          mul_sum: begin
            state_next = done;
            // sums wrap at 16 bits
            mul_a      = op_a_re + op_a_im;
            mul_b      = op_b_re + op_b_im;
          end
          done: begin
            // hold the result until the consumer takes it
            if (send_rdy) begin
              state_next = idle;
            end
          end
          default: state_next = idle;
        endcase
      end

      fixed_mult u_mult (.a(mul_a), .b(mul_b), .c(mul_c));

      // outputs only meaningful in done
      assign c_re = p_rr - p_ii;
      assign c_im = p_sum - p_rr - p_ii;
    end
  endgenerate

endmodule

`default_nettype wire

//--- rtl/twiddle_rom.sv
`default_nettype none

module twiddle_rom (
  input  butterfly_pkg::twiddle_index_t index,
  output fixed_point_pkg::sample_t      w_re,
  output fixed_point_pkg::sample_t      w_im
);

  import fixed_point_pkg::*;

  // W8^k = exp(-j*2*pi*k/8) = cos(2*pi*k/8) - j*sin(2*pi*k/8)
  // stored as (cos, -sin) in Q2.14
  // 11585 is round(16384 / sqrt(2))

  always_comb begin
    // unity twiddle unless the index says otherwise
    w_re = sample_t'(16384);
    w_im = sample_t'(0);
    case (index)
      // W8^0 = 1
      2'd0: begin
        w_re = sample_t'(16384);
        w_im = sample_t'(0);
      end
      // W8^1 = (1 - j) / sqrt(2)
      2'd1: begin
        w_re = sample_t'(11585);
        w_im = sample_t'(-11585);
      end
      // W8^2 = -j
      2'd2: begin
        w_re = sample_t'(0);
        w_im = sample_t'(-16384);
      end
      // W8^3 = (-1 - j) / sqrt(2)
      2'd3: begin
        w_re = sample_t'(-11585);
        w_im = sample_t'(-11585);
      end
      default: begin
        w_re = sample_t'(16384);
        w_im = sample_t'(0);
      end
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/butterfly.sv
`default_nettype none

module butterfly #(
  parameter int num_mults = 1
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     in_val,
  output logic                     in_rdy,
  input  fixed_point_pkg::sample_t x0_re,
  input  fixed_point_pkg::sample_t x0_im,
  output logic                     mul_recv_val,
  input  logic                     mul_recv_rdy,
  input  logic                     mul_send_val,
  output logic                     mul_send_rdy,
  input  fixed_point_pkg::sample_t t_re,
  input  fixed_point_pkg::sample_t t_im,
  output logic                     out_val,
  input  logic                     out_rdy,
  output fixed_point_pkg::sample_t y0_re,
  output fixed_point_pkg::sample_t y0_im,
  output fixed_point_pkg::sample_t y1_re,
  output fixed_point_pkg::sample_t y1_im
);

  import fixed_point_pkg::*;

  // x0 that pairs with the current product
  sample_t x0_re_use;
  sample_t x0_im_use;
  // product transfer from the multiplier
  logic    load;

  // the input is accepted exactly when the multiplier takes x1
  assign mul_recv_val = in_val;
  assign in_rdy       = mul_recv_rdy;

  // output register free, or emptied this cycle
  assign mul_send_rdy = !out_val || out_rdy;
  assign load         = mul_send_val && mul_send_rdy;

  generate
    if (num_mults == 3) begin : g_live
      // product comes back in the accepting cycle, x0 is still on the inputs
      assign x0_re_use = x0_re;
      assign x0_im_use = x0_im;
    end else begin : g_hold
      sample_t x0_re_q;
      sample_t x0_im_q;

      // keep x0 for the length of the multiply
      always_ff @(posedge clk) begin
        if (in_val && mul_recv_rdy) begin
          x0_re_q <= x0_re;
          x0_im_q <= x0_im;
        end
      end

      assign x0_re_use = x0_re_q;
      assign x0_im_use = x0_im_q;
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (reset) begin
      out_val <= 1'b0;
    end else if (load) begin
      out_val <= 1'b1;
    end else if (out_rdy) begin
      out_val <= 1'b0;
    end
  end

  // y0 = x0 + t, y1 = x0 - t, both wrap at 16 bits
  always_ff @(posedge clk) begin
    if (load) begin
      y0_re <= x0_re_use + t_re;
      y0_im <= x0_im_use + t_im;
      y1_re <= x0_re_use - t_re;
      y1_im <= x0_im_use - t_im;
    end
  end

endmodule

`default_nettype wire

//--- rtl/butterfly_unit.sv
`default_nettype none

module butterfly_unit #(
  parameter int num_mults = 1
) (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_val,
  output logic                          in_rdy,
  input  fixed_point_pkg::sample_t      x0_re,
  input  fixed_point_pkg::sample_t      x0_im,
  input  fixed_point_pkg::sample_t      x1_re,
  input  fixed_point_pkg::sample_t      x1_im,
  input  butterfly_pkg::twiddle_index_t twiddle_index,
  output logic                          out_val,
  input  logic                          out_rdy,
  output fixed_point_pkg::sample_t      y0_re,
  output fixed_point_pkg::sample_t      y0_im,
  output fixed_point_pkg::sample_t      y1_re,
  output fixed_point_pkg::sample_t      y1_im
);

  import fixed_point_pkg::*;

  // twiddle factor, straight from the table
  sample_t w_re;
  sample_t w_im;
  // t = w * x1
  sample_t t_re;
  sample_t t_im;
  // handshake between butterfly and multiplier
  logic    mul_recv_val;
  logic    mul_recv_rdy;
  logic    mul_send_val;
  logic    mul_send_rdy;

  twiddle_rom u_twiddle_rom (
    .index (twiddle_index),
    .w_re  (w_re),
    .w_im  (w_im)
  );

  complex_mult #(
    .num_mults (num_mults)
  ) u_complex_mult (
    .clk      (clk),
    .reset    (reset),
    .recv_val (mul_recv_val),
    .recv_rdy (mul_recv_rdy),
    .send_val (mul_send_val),
    .send_rdy (mul_send_rdy),
    .a_re     (x1_re),
    .a_im     (x1_im),
    .b_re     (w_re),
    .b_im     (w_im),
    .c_re     (t_re),
    .c_im     (t_im)
  );

  butterfly #(
    .num_mults (num_mults)
  ) u_butterfly (
    .clk          (clk),
    .reset        (reset),
    .in_val       (in_val),
    .in_rdy       (in_rdy),
    .x0_re        (x0_re),
    .x0_im        (x0_im),
    .mul_recv_val (mul_recv_val),
    .mul_recv_rdy (mul_recv_rdy),
    .mul_send_val (mul_send_val),
    .mul_send_rdy (mul_send_rdy),
    .t_re         (t_re),
    .t_im         (t_im),
    .out_val      (out_val),
    .out_rdy      (out_rdy),
    .y0_re        (y0_re),
    .y0_im        (y0_im),
    .y1_re        (y1_re),
    .y1_im        (y1_im)
  );

endmodule

`default_nettype wire

//--- test/tb_clock.sv
`default_nettype none

module tb_clock #(
  parameter int period_ns = 20
) (
  output logic clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // starts low, first rising edge half a period in
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

endmodule

`default_nettype wire

//--- test/butterfly_unit_tb.sv
`default_nettype none

module butterfly_unit_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import fixed_point_pkg::*;
  import butterfly_pkg::*;

  // the tests need well under half of this
  localparam int timeout_cycles = 2000;

  logic           clk;
  logic           reset;
  logic           in_val;
  logic           in_rdy;
  sample_t        x0_re;
  sample_t        x0_im;
  sample_t        x1_re;
  sample_t        x1_im;
  twiddle_index_t twiddle_index;
  logic           out_val;
  logic           out_rdy;
  sample_t        y0_re;
  sample_t        y0_im;
  sample_t        y1_re;
  sample_t        y1_im;

  integer      seed;
  int          cycle_count = 0;
  int          check_count = 0;
  int          error_count = 0;
  // expected {y0_re, y0_im, y1_re, y1_im} of accepted inputs, oldest first
  logic [63:0] expected_q[$];

  tb_clock #(.period_ns(20)) u_clock (.clk(clk));

  butterfly_unit #(
    .num_mults (1)
  ) i_dut (
    .clk           (clk),
    .reset         (reset),
    .in_val        (in_val),
    .in_rdy        (in_rdy),
    .x0_re         (x0_re),
    .x0_im         (x0_im),
    .x1_re         (x1_re),
    .x1_im         (x1_im),
    .twiddle_index (twiddle_index),
    .out_val       (out_val),
    .out_rdy       (out_rdy),
    .y0_re         (y0_re),
    .y0_im         (y0_im),
    .y1_re         (y1_re),
    .y1_im         (y1_im)
  );

  // Q2.14 product, full signed product shifted right by 14, low word kept
  function automatic sample_t scaled_product(input sample_t a, input sample_t b);
    int full;
    int shifted;
    full    = int'(a) * int'(b);
    shifted = full >>> frac_bits;
    return shifted[15:0];
  endfunction

  // W8^k as {cos, -sin} of 2*pi*k/8
  function automatic logic [31:0] twiddle_value(input twiddle_index_t k);
    sample_t w_re;
    sample_t w_im;
    case (k)
      2'd1: begin
        w_re = 16'sd11585;
        w_im = -16'sd11585;
      end
      2'd2: begin
        w_re = 16'sd0;
        w_im = -16'sd16384;
      end
      2'd3: begin
        w_re = -16'sd11585;
        w_im = -16'sd11585;
      end
      default: begin
        w_re = 16'sd16384;
        w_im = 16'sd0;
      end
    endcase
    return {w_re, w_im};
  endfunction

  // y0 = x0 + w*x1, y1 = x0 - w*x1 with the three-product rule, all wrapping
  function automatic logic [63:0] model_butterfly(input sample_t a_re, input sample_t a_im,
                                                  input sample_t b_re, input sample_t b_im,
                                                  input twiddle_index_t k);
    logic [31:0] w;
    sample_t     p_rr;
    sample_t     p_ii;
    sample_t     p_sum;
    sample_t     t_re;
    sample_t     t_im;
    sample_t     e0_re;
    sample_t     e0_im;
    sample_t     e1_re;
    sample_t     e1_im;
    w     = twiddle_value(k);
    p_rr  = scaled_product(b_re, w[31:16]);
    p_ii  = scaled_product(b_im, w[15:0]);
    p_sum = scaled_product(b_re + b_im, w[31:16] + w[15:0]);
    t_re  = p_rr - p_ii;
    t_im  = p_sum - p_rr - p_ii;
    e0_re = a_re + t_re;
    e0_im = a_im + t_im;
    e1_re = a_re - t_re;
    e1_im = a_im - t_im;
    return {e0_re, e0_im, e1_re, e1_im};
  endfunction

  function automatic sample_t random_sample();
    int r;
    r = $random(seed);
    return r[15:0];
  endfunction

  task automatic check_flag(input string name, input logic got, input logic want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic check_word(input string name, input sample_t got, input sample_t want);
    check_count++;
    if (got !== want) begin
      error_count++;
      $display("CHECK FAILED %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic compare_result(input logic [63:0] want, input string label);
    check_word({label, " y0_re"}, y0_re, want[63:48]);
    check_word({label, " y0_im"}, y0_im, want[47:32]);
    check_word({label, " y1_re"}, y1_re, want[31:16]);
    check_word({label, " y1_im"}, y1_im, want[15:0]);
  endtask

  // hold one input until the handshake, returns 2 ns after the accepting edge
  task automatic send_item(input sample_t s0_re, input sample_t s0_im,
                           input sample_t s1_re, input sample_t s1_im,
                           input twiddle_index_t idx);
    in_val        = 1'b1;
    x0_re         = s0_re;
    x0_im         = s0_im;
    x1_re         = s1_re;
    x1_im         = s1_im;
    twiddle_index = idx;
    // in_rdy comes from registers, settled by now
    while (!in_rdy) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
    in_val = 1'b0;
  endtask

  // wait for a result, check it and take it on the next edge
  task automatic take_result(input logic [63:0] want, input string label);
    out_rdy = 1'b1;
    while (!out_val) begin
      @(posedge clk);
      #2;
    end
    compare_result(want, label);
    @(posedge clk);
    #2;
  endtask

  task automatic unity_case(input sample_t s0_re, input sample_t s0_im,
                            input sample_t s1_re, input sample_t s1_im);
    sample_t e0_re;
    sample_t e0_im;
    sample_t e1_re;
    sample_t e1_im;
    // w = 1.0, so t is x1 itself
    e0_re = s0_re + s1_re;
    e0_im = s0_im + s1_im;
    e1_re = s0_re - s1_re;
    e1_im = s0_im - s1_im;
    send_item(s0_re, s0_im, s1_re, s1_im, 2'd0);
    take_result({e0_re, e0_im, e1_re, e1_im}, "unity");
  endtask

  task automatic test_unity_twiddle();
    unity_case(16'sd0, 16'sd0, 16'sd0, 16'sd0);
    unity_case(16'sd100, -16'sd200, 16'sd300, 16'sd400);
    unity_case(16'sd16384, -16'sd16384, 16'sd16384, 16'sd16384);
    // sums past full scale wrap around
    unity_case(16'sh7fff, 16'sh7fff, 16'sd1, 16'sd1);
    unity_case(16'sh8000, 16'sh8000, 16'sd1, -16'sd1);
    unity_case(16'sh7fff, 16'sh8000, 16'sh7fff, 16'sh8000);
    unity_case(16'sh8000, 16'sh7fff, 16'sh8000, 16'sh7fff);
    unity_case(-16'sd1, 16'sd1, 16'sh8000, 16'sh8000);
  endtask

  task automatic test_all_twiddles();
    sample_t s0_re;
    sample_t s0_im;
    sample_t s1_re;
    sample_t s1_im;
    for (int k = 0; k < 4; k++) begin
      repeat (4) begin
        s0_re = random_sample();
        s0_im = random_sample();
        s1_re = random_sample();
        s1_im = random_sample();
        send_item(s0_re, s0_im, s1_re, s1_im, twiddle_index_t'(k));
        take_result(model_butterfly(s0_re, s0_im, s1_re, s1_im, twiddle_index_t'(k)),
                    $sformatf("twiddle %0d", k));
      end
    end
  endtask

  task automatic test_latency();
    int waited;
    waited  = 0;
    out_rdy = 1'b1;
    send_item(16'sd1000, -16'sd2000, 16'sd3000, 16'sd4000, 2'd1);
    // one count per edge after the accepting one
    while (!out_val && waited < 20) begin
      check_flag("in_rdy while busy", in_rdy, 1'b0);
      @(posedge clk);
      #2;
      waited++;
    end
    check_count++;
    if (waited != 5) begin
      error_count++;
      $display("CHECK FAILED latency: got %h expected %h", waited, 5);
    end
    take_result(model_butterfly(16'sd1000, -16'sd2000, 16'sd3000, 16'sd4000, 2'd1), "latency");
  endtask

  task automatic test_back_pressure();
    logic [63:0] exp_a;
    logic [63:0] exp_b;
    int          taken;
    exp_a   = model_butterfly(16'sd5000, -16'sd6000, 16'sd7000, -16'sd8000, 2'd3);
    exp_b   = model_butterfly(-16'sd1234, 16'sd2345, 16'sd3456, -16'sd4567, 2'd2);
    out_rdy = 1'b0;
    send_item(16'sd5000, -16'sd6000, 16'sd7000, -16'sd8000, 2'd3);
    // second item ends up parked in the multiplier behind the stalled result
    send_item(-16'sd1234, 16'sd2345, 16'sd3456, -16'sd4567, 2'd2);
    repeat (12) begin
      check_flag("out_val held", out_val, 1'b1);
      check_flag("in_rdy held", in_rdy, 1'b0);
      compare_result(exp_a, "held");
      @(posedge clk);
      #2;
    end
    out_rdy = 1'b1;
    taken   = 0;
    repeat (10) begin
      if (out_val) begin
        if (taken == 0) begin
          compare_result(exp_a, "released first");
        end else if (taken == 1) begin
          compare_result(exp_b, "released second");
        end
        taken++;
      end
      @(posedge clk);
      #2;
    end
    check_count++;
    if (taken != 2) begin
      error_count++;
      $display("expected two results after release, but %0d were taken", taken);
    end
  endtask

  task automatic stream_inputs(input int count);
    sample_t        s0_re;
    sample_t        s0_im;
    sample_t        s1_re;
    sample_t        s1_im;
    twiddle_index_t idx;
    int             r;
    for (int i = 0; i < count; i++) begin
      s0_re = random_sample();
      s0_im = random_sample();
      s1_re = random_sample();
      s1_im = random_sample();
      r     = $random(seed);
      idx   = r[1:0];
      send_item(s0_re, s0_im, s1_re, s1_im, idx);
      expected_q.push_back(model_butterfly(s0_re, s0_im, s1_re, s1_im, idx));
    end
  endtask

  // random out_rdy each cycle, results must come back in input order
  task automatic stream_outputs(input int count);
    int received;
    int r;
    received = 0;
    while (received < count) begin
      r       = $random(seed);
      out_rdy = r[0];
      if (out_val && out_rdy) begin
        if (expected_q.size() == 0) begin
          error_count++;
          $display("a result came out with no input pending");
        end else begin
          compare_result(expected_q.pop_front(), $sformatf("stream %0d", received));
        end
        received++;
      end
      @(posedge clk);
      #2;
    end
  endtask

  task automatic test_streaming();
    fork
      stream_inputs(20);
      stream_outputs(20);
    join
    out_rdy = 1'b1;
    // nothing beyond the 20 results
    repeat (8) begin
      check_flag("out_val after stream", out_val, 1'b0);
      @(posedge clk);
      #2;
    end
    check_count++;
    if (expected_q.size() != 0) begin
      error_count++;
      $display("%0d streamed inputs never produced a result", expected_q.size());
    end
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("run stopped after %0d cycles with tests still running", cycle_count);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      $display("Result: FAILED");
      $finish;
    end
  end

  initial begin
    seed          = 32'h4710;
    reset         = 1'b1;
    in_val        = 1'b0;
    x0_re         = '0;
    x0_im         = '0;
    x1_re         = '0;
    x1_im         = '0;
    twiddle_index = '0;
    out_rdy       = 1'b1;
    repeat (16) begin
      @(posedge clk);
    end
    #2;
    reset = 1'b0;
    check_flag("out_val after reset", out_val, 1'b0);
    check_flag("in_rdy after reset", in_rdy, 1'b1);
    test_unity_twiddle();
    test_all_twiddles();
    test_latency();
    test_back_pressure();
    test_streaming();
    $display("checks: %0d  errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
rtl/fixed_point_pkg.sv
rtl/butterfly_pkg.sv
rtl/fixed_mult.sv
rtl/complex_mult.sv
rtl/twiddle_rom.sv
rtl/butterfly.sv
rtl/butterfly_unit.sv
test/tb_clock.sv
test/butterfly_unit_tb.sv

//--- Makefile
TOP = butterfly_unit_tb

.PHONY: all compile run clean

all: run

# verilate and build the simulation binary from the file list
compile:
	verilator --binary --timing --timescale 1ns/1ps -f project.f --top-module $(TOP) -Mdir obj_dir

# passes only when the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf obj_dir
